//--- source/ecc_pkg.sv
// ECC code constants, check word type and the column table of the
// 64-by-8 check matrix shared by the checker and the reference model
`default_nettype none

package ecc_pkg;

  localparam int DATA_W  = 64;
  localparam int CHECK_W = 8;

  // Check bits and syndromes share one type
  typedef logic [CHECK_W-1:0] check_t;

  // Entry i lists the check bits fed by data bit i
  // Bits 0 to 6 follow Hamming positions and bit 7 completes odd column weight
  localparam check_t H_COLUMNS [DATA_W] = '{
    // Data 0 to 7
    8'h83, 8'h85, 8'h86, 8'h07, 8'h89, 8'h8a, 8'h0b, 8'h8c,
    // Data 8 to 15
    8'h0d, 8'h0e, 8'h8f, 8'h91, 8'h92, 8'h13, 8'h94, 8'h15,
    // Data 16 to 23
    8'h16, 8'h97, 8'h98, 8'h19, 8'h1a, 8'h9b, 8'h1c, 8'h9d,
    // Data 24 to 31
    8'h9e, 8'h1f, 8'ha1, 8'ha2, 8'h23, 8'ha4, 8'h25, 8'h26,
    // Data 32 to 39
    8'ha7, 8'ha8, 8'h29, 8'h2a, 8'hab, 8'h2c, 8'had, 8'hae,
    // Data 40 to 47
    8'h2f, 8'hb0, 8'h31, 8'h32, 8'hb3, 8'h34, 8'hb5, 8'hb6,
    // Data 48 to 55
    8'h37, 8'h38, 8'hb9, 8'hba, 8'h3b, 8'hbc, 8'h3d, 8'h3e,
    // Data 56 to 63
    8'hbf, 8'hc1, 8'hc2, 8'h43, 8'hc4, 8'h45, 8'h46, 8'hc7
  };

  // Every column has odd weight of three or more, so no column is one-hot
  // or zero and a single data error never looks like a check error

endpackage : ecc_pkg

`default_nettype wire

//--- source/rf_pkg.sv
// Register file sizes, status encoding, and the command, response and
// stored word structs
`default_nettype none

package rf_pkg;

  localparam int DEPTH  = 16;
  localparam int ADDR_W = 4;

  // Read status
  typedef enum logic [1:0] {
    STAT_CLEAN      = 2'd0,
    STAT_CORR_DATA  = 2'd1,
    STAT_CORR_CHECK = 2'd2,
    STAT_UNCORR     = 2'd3
  } ecc_status_e;

  // Request from the requester, held stable while req is high
  typedef struct packed {
    logic                         write;
    logic [ADDR_W-1:0]            addr;
    logic [ecc_pkg::DATA_W-1:0]   data;
    ecc_pkg::check_t              inject;
  } rf_cmd_t;

  // Response, valid while ack is high
  typedef struct packed {
    logic [ecc_pkg::DATA_W-1:0]   data;
    ecc_pkg::check_t              check;
    ecc_status_e                  status;
  } rf_rsp_t;

  // One array entry
  typedef struct packed {
    logic [ecc_pkg::DATA_W-1:0]   data;
    ecc_pkg::check_t              check;
  } rf_word_t;

endpackage : rf_pkg

`default_nettype wire

//--- source/ecc_gen.sv
// Two-stage 64-to-8 check bit generator with check bit inversion for
// error injection
`timescale 1ns/1ns
`default_nettype none

module ecc_gen (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic [ecc_pkg::DATA_W-1:0] data,
  input  ecc_pkg::check_t            inject,
  output ecc_pkg::check_t            check
);

  // Partial parities held between the two stages
  typedef struct packed {
    logic [7:0] p0;
    logic [7:0] p1;
    logic [7:0] p2;
    logic [7:0] p3;
    logic [3:0] p4;
    logic [1:0] p5;
    logic [1:0] p6;
    logic [7:0] p7;
    logic [1:0] msk;
  } partial_t;

  partial_t part_d;
  partial_t part_q;

  // Stage 1 groups of four to eight data bits
  always_comb begin
    part_d.p0[0] = data[0] ^ data[1] ^ data[3] ^ data[4];
    part_d.p0[1] = data[6] ^ data[8] ^ data[10] ^ data[11];
    part_d.p0[2] = data[13] ^ data[15] ^ data[17] ^ data[19];
    part_d.p0[3] = data[21] ^ data[23] ^ data[25] ^ data[26];
    part_d.p0[4] = data[28] ^ data[30] ^ data[32] ^ data[34];
    part_d.p0[5] = data[36] ^ data[38] ^ data[40] ^ data[42];
    part_d.p0[6] = data[44] ^ data[46] ^ data[48] ^ data[50];
    part_d.p0[7] = data[52] ^ data[54] ^ data[56] ^ data[57] ^ data[59] ^ data[61] ^
                   data[63] ^ inject[0];

    part_d.p1[0] = data[0] ^ data[2] ^ data[3] ^ data[5];
    part_d.p1[1] = data[6] ^ data[9] ^ data[10] ^ data[12];
    part_d.p1[2] = data[13] ^ data[16] ^ data[17] ^ data[20];
    part_d.p1[3] = data[21] ^ data[24] ^ data[25] ^ data[27];
    part_d.p1[4] = data[28] ^ data[31] ^ data[32] ^ data[35];
    part_d.p1[5] = data[36] ^ data[39] ^ data[40] ^ data[43];
    part_d.p1[6] = data[44] ^ data[47] ^ data[48] ^ data[51];
    part_d.p1[7] = data[52] ^ data[55] ^ data[56] ^ data[58] ^ data[59] ^ data[62] ^
                   data[63] ^ inject[1];

    part_d.p2[0] = data[1] ^ data[2] ^ data[3] ^ data[7];
    part_d.p2[1] = data[8] ^ data[9] ^ data[10] ^ data[14];
    part_d.p2[2] = data[15] ^ data[16] ^ data[17] ^ data[22];
    part_d.p2[3] = data[23] ^ data[24] ^ data[25] ^ data[29];
    part_d.p2[4] = data[30] ^ data[31] ^ data[32] ^ data[37];
    part_d.p2[5] = data[38] ^ data[39] ^ data[40] ^ data[45];
    part_d.p2[6] = data[46] ^ data[47] ^ data[48] ^ data[53];
    part_d.p2[7] = data[54] ^ data[55] ^ data[56] ^ data[60] ^ data[61] ^ data[62] ^
                   data[63] ^ inject[2];

    part_d.p3[0] = data[4] ^ data[5] ^ data[6] ^ data[7];
    part_d.p3[1] = data[8] ^ data[9] ^ data[10] ^ data[18];
    part_d.p3[2] = data[19] ^ data[20] ^ data[21] ^ data[22];
    part_d.p3[3] = data[23] ^ data[24] ^ data[25] ^ data[33];
    part_d.p3[4] = data[34] ^ data[35] ^ data[36] ^ data[37];
    part_d.p3[5] = data[38] ^ data[39] ^ data[40] ^ data[49];
    part_d.p3[6] = data[50] ^ data[51] ^ data[52] ^ data[53];
    part_d.p3[7] = data[54] ^ data[55] ^ data[56] ^ inject[3];

    // Groups 2 and 3 also feed check bit 5
    part_d.p4[0] = ^data[18:11];
    part_d.p4[1] = (^data[25:19]) ^ data[41];
    part_d.p4[2] = ^data[49:42];
    part_d.p4[3] = ^data[56:50];

    part_d.p5[0] = ^data[33:26];
    part_d.p5[1] = ^data[41:34];

    part_d.p6[0] = ^data[60:57];
    part_d.p6[1] = (^data[63:61]) ^ inject[6];

    part_d.p7[0] = data[0] ^ data[1] ^ data[2] ^ data[4];
    part_d.p7[1] = data[5] ^ data[7] ^ data[10] ^ data[11];
    part_d.p7[2] = data[12] ^ data[14] ^ data[17] ^ data[18];
    part_d.p7[3] = data[21] ^ data[23] ^ data[24] ^ data[26];
    part_d.p7[4] = data[27] ^ data[29] ^ data[32] ^ data[33];
    part_d.p7[5] = data[36] ^ data[38] ^ data[39] ^ data[41];
    part_d.p7[6] = data[44] ^ data[46] ^ data[47] ^ data[50];
    part_d.p7[7] = data[51] ^ data[53] ^ data[56] ^ data[57] ^ data[58] ^ data[60] ^
                   data[63] ^ inject[7];

    // Bits 4 and 5 have no spare group input, so their masks go late
    part_d.msk = inject[5:4];
  end

  always_ff @(posedge clk) begin
    part_q <= part_d;
  end

  // Stage 2 folds the partials into the check word
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      check <= '0;
    end else begin
      check[0] <= ^part_q.p0;
      check[1] <= ^part_q.p1;
      check[2] <= ^part_q.p2;
      check[3] <= ^part_q.p3;
      check[4] <= (^part_q.p4) ^ part_q.msk[0];
      check[5] <= (^part_q.p5) ^ (^part_q.p4[3:2]) ^ part_q.msk[1];
      check[6] <= ^part_q.p6;
      check[7] <= ^part_q.p7;
    end
  end

endmodule : ecc_gen

`default_nettype wire

//--- source/ecc_check.sv
// Syndrome computation, error classification and single data bit
// correction for one stored word
`timescale 1ns/1ns
`default_nettype none

module ecc_check (
  input  rf_pkg::rf_word_t           word,
  output logic [ecc_pkg::DATA_W-1:0] data,
  output rf_pkg::ecc_status_e        status
);

  ecc_pkg::check_t               parity;
  ecc_pkg::check_t               syndrome;
  logic [ecc_pkg::DATA_W-1:0]    flip;

  // Parity of the stored data, rebuilt from the column table
  always_comb begin
    parity = '0;
    for (int i = 0; i < ecc_pkg::DATA_W; i++) begin
      if (word.data[i]) begin
        parity = parity ^ ecc_pkg::H_COLUMNS[i];
      end
    end
  end

  assign syndrome = parity ^ word.check;

  // A syndrome matching one column points at the failing data bit
  always_comb begin
    for (int i = 0; i < ecc_pkg::DATA_W; i++) begin
      flip[i] = (syndrome == ecc_pkg::H_COLUMNS[i]);
    end
  end

  // Uncorrectable words pass through unchanged since flip is zero then
  assign data = word.data ^ flip;

  always_comb begin
    if (syndrome == '0) begin
      status = rf_pkg::STAT_CLEAN;
    end else if (|flip) begin
      status = rf_pkg::STAT_CORR_DATA;
    end else if ($onehot(syndrome)) begin
      // Only a check bit flipped, data is already good
      status = rf_pkg::STAT_CORR_CHECK;
    end else begin
      status = rf_pkg::STAT_UNCORR;
    end
  end

endmodule : ecc_check

`default_nettype wire

//--- source/ecc_rf_array.sv
// 16-entry by 72-bit word storage with synchronous write and registered read
`timescale 1ns/1ns
`default_nettype none

module ecc_rf_array (
  input  logic                      clk,
  input  logic                      we,
  input  logic [rf_pkg::ADDR_W-1:0] waddr,
  input  rf_pkg::rf_word_t          wword,
  input  logic [rf_pkg::ADDR_W-1:0] raddr,
  output rf_pkg::rf_word_t          rword
);

  rf_pkg::rf_word_t mem [rf_pkg::DEPTH];

  always_ff @(posedge clk) begin
    if (we) begin
      mem[waddr] <= wword;
    end
  end

  // Read port sees the old word if both hit one entry on the same edge
  always_ff @(posedge clk) begin
    rword <= mem[raddr];
  end

endmodule : ecc_rf_array

`default_nettype wire

//--- source/ecc_rf_ctrl.sv
// Four-phase handshake sequencer stepping one command through encode,
// store, read and check with a fixed three-cycle latency
`timescale 1ns/1ns
`default_nettype none

module ecc_rf_ctrl (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       req,
  input  rf_pkg::rf_cmd_t            cmd,
  output logic                       ack,
  input  ecc_pkg::check_t            gen_check,
  input  logic [ecc_pkg::DATA_W-1:0] chk_data,
  input  rf_pkg::ecc_status_e        chk_status,
  input  ecc_pkg::check_t            rword_check,
  output logic                       we,
  output rf_pkg::rf_rsp_t            rsp
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_BUSY,
    ST_ACKED
  } state_e;

  state_e     state;
  logic [1:0] cnt;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state <= ST_IDLE;
      cnt   <= '0;
      we    <= 1'b0;
      rsp   <= '0;
    end else begin
      we <= 1'b0;
      case (state)
        ST_IDLE: begin
          if (req) begin
            state <= ST_BUSY;
            cnt   <= 2'd1;
          end
        end
        ST_BUSY: begin
          cnt <= cnt + 2'd1;
          // Check word settles after edge 1, so the array writes at edge 2
          if (cnt == 2'd1) begin
            we <= cmd.write;
          end
          if (cnt == 2'd3) begin
            state <= ST_ACKED;
            if (cmd.write) begin
              rsp.data   <= cmd.data;
              rsp.check  <= gen_check;
              rsp.status <= rf_pkg::STAT_CLEAN;
            end else begin
              rsp.data   <= chk_data;
              rsp.check  <= rword_check;
              rsp.status <= chk_status;
            end
          end
        end
        ST_ACKED: begin
          // Response holds until the requester lets go
          if (!req) begin
            state <= ST_IDLE;
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  assign ack = (state == ST_ACKED);

endmodule : ecc_rf_ctrl

`default_nettype wire

//--- source/ecc_rf_top.sv
// Top level of the ECC register file slice, connecting the controller,
// the check bit generator, the word array and the checker
`timescale 1ns/1ns
`default_nettype none

module ecc_rf_top (
  input  logic            clk,
  input  logic            rst_n,
  input  logic            req,
  input  rf_pkg::rf_cmd_t cmd,
  output logic            ack,
  output rf_pkg::rf_rsp_t rsp
);

  ecc_pkg::check_t               gen_check;
  logic                          we;
  rf_pkg::rf_word_t              wword;
  rf_pkg::rf_word_t              rword;
  logic [ecc_pkg::DATA_W-1:0]    chk_data;
  rf_pkg::ecc_status_e           chk_status;

  assign wword.data  = cmd.data;
  assign wword.check = gen_check;

  ecc_rf_ctrl u_ecc_rf_ctrl (
    .clk         (clk),
    .rst_n       (rst_n),
    .req         (req),
    .cmd         (cmd),
    .ack         (ack),
    .gen_check   (gen_check),
    .chk_data    (chk_data),
    .chk_status  (chk_status),
    .rword_check (rword.check),
    .we          (we),
    .rsp         (rsp)
  );

  ecc_gen u_ecc_gen (
    .clk    (clk),
    .rst_n  (rst_n),
    .data   (cmd.data),
    .inject (cmd.inject),
    .check  (gen_check)
  );

  ecc_rf_array u_ecc_rf_array (
    .clk   (clk),
    .we    (we),
    .waddr (cmd.addr),
    .wword (wword),
    .raddr (cmd.addr),
    .rword (rword)
  );

  ecc_check u_ecc_check (
    .word   (rword),
    .data   (chk_data),
    .status (chk_status)
  );

endmodule : ecc_rf_top

`default_nettype wire

//--- tb/ecc_rf_asserts.sv
// Concurrent checks on the controller handshake, the write enable and
// the response, bound into every ecc_rf_ctrl instance
`timescale 1ns/1ns
`default_nettype none

module ecc_rf_asserts (
  input logic            clk,
  input logic            rst_n,
  input logic            req,
  input logic            ack,
  input logic            we,
  input rf_pkg::rf_rsp_t rsp
);

  // Failure count, read by the testbench at the end of the run
  int unsigned fail_cnt = 0;

  // ack registers at edge 3 and is first sampled high one edge later
  ack_latency: assert property (@(posedge clk) disable iff (!rst_n)
    $rose(req) |-> !ack [*4] ##1 ack)
    else begin
      fail_cnt++;
      $error("ack did not rise three edges after req");
    end

  ack_release: assert property (@(posedge clk) disable iff (!rst_n)
    $fell(req) |-> ack ##1 !ack)
    else begin
      fail_cnt++;
      $error("ack did not fall one edge after req fell");
    end

  rsp_hold: assert property (@(posedge clk) disable iff (!rst_n)
    (ack && $past(ack)) |-> $stable(rsp))
    else begin
      fail_cnt++;
      $error("rsp changed while ack was high");
    end

  // A held request must not start a second write
  no_write_acked: assert property (@(posedge clk) disable iff (!rst_n)
    ack |-> !we)
    else begin
      fail_cnt++;
      $error("write enable high while ack was high");
    end

  ack_reset: assert property (@(posedge clk) !rst_n |=> !ack)
    else begin
      fail_cnt++;
      $error("ack not low after reset");
    end

endmodule : ecc_rf_asserts

bind ecc_rf_ctrl ecc_rf_asserts u_ecc_rf_asserts (
  .clk   (clk),
  .rst_n (rst_n),
  .req   (req),
  .ack   (ack),
  .we    (we),
  .rsp   (rsp)
);

`default_nettype wire

//--- tb/ecc_rf_tb.sv
// Testbench for the ECC register file slice with LFSR stimulus, a model
// of the stored words and error counting
`timescale 1ns/1ns
`default_nettype none

module ecc_rf_tb;

  localparam int NUM_CMDS       = 44;
  localparam int RESET_CYCLES   = 10;
  localparam int TIMEOUT_CYCLES = NUM_CMDS * 8 + RESET_CYCLES + 50;

  logic             clk = 1'b0;
  logic             rst_n;
  logic             req;
  rf_pkg::rf_cmd_t  cmd;
  logic             ack;
  rf_pkg::rf_rsp_t  rsp;

  logic [15:0]      lfsr = 16'd11;
  int unsigned      check_errors = 0;
  int unsigned      cycles = 0;
  rf_pkg::rf_word_t model_mem [rf_pkg::DEPTH];
  ecc_pkg::check_t  model_inject [rf_pkg::DEPTH];
  logic             model_valid [rf_pkg::DEPTH];

  ecc_rf_top u_ecc_rf_top (
    .clk   (clk),
    .rst_n (rst_n),
    .req   (req),
    .cmd   (cmd),
    .ack   (ack),
    .rsp   (rsp)
  );

  always #20 clk = ~clk;

  // Galois form, taps for x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return (s >> 1) ^ (s[0] ? 16'hb400 : 16'h0000);
  endfunction

  task automatic draw_bits(input int n, output logic [63:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      v[i] = lfsr[0];
      lfsr = lfsr_next(lfsr);
    end
  endtask

  // Expected check word as the XOR of the columns of all set data bits
  function automatic ecc_pkg::check_t column_parity(input logic [63:0] d);
    ecc_pkg::check_t p;
    p = '0;
    for (int i = 0; i < ecc_pkg::DATA_W; i++) begin
      if (d[i]) begin
        p = p ^ ecc_pkg::H_COLUMNS[i];
      end
    end
    return p;
  endfunction

  task automatic compare_value(input string name, input logic [79:0] exp,
                               input logic [79:0] act);
    assert (act === exp) else begin
      check_errors++;
      $display("MISMATCH %s expected %0h actual %0h", name, exp, act);
    end
  endtask

  // One four-phase transfer, with req held for extra cycles after ack
  task automatic run_command(input rf_pkg::rf_cmd_t c, input int hold,
                             output rf_pkg::rf_rsp_t r);
    req <= 1'b1;
    cmd <= c;
    do begin
      @(posedge clk);
    end while (ack !== 1'b1);
    r = rsp;
    for (int k = 0; k < hold; k++) begin
      @(posedge clk);
      assert (ack === 1'b1) else begin
        check_errors++;
        $display("ack dropped while req was still held high");
      end
      compare_value("hold rsp", r, rsp);
    end
    req <= 1'b0;
    do begin
      @(posedge clk);
    end while (ack !== 1'b0);
  endtask

  task automatic write_entry(input string name, input logic [3:0] addr,
                             input logic [63:0] data, input ecc_pkg::check_t inject,
                             input int hold);
    rf_pkg::rf_cmd_t c;
    rf_pkg::rf_rsp_t r;
    ecc_pkg::check_t exp_check;
    exp_check = column_parity(data) ^ inject;
    c.write  = 1'b1;
    c.addr   = addr;
    c.data   = data;
    c.inject = inject;
    run_command(c, hold, r);
    compare_value({name, " write data"}, data, r.data);
    compare_value({name, " write check"}, exp_check, r.check);
    compare_value({name, " write status"}, rf_pkg::STAT_CLEAN, r.status);
    model_mem[addr].data  = data;
    model_mem[addr].check = exp_check;
    model_inject[addr]    = inject;
    model_valid[addr]     = 1'b1;
  endtask

  task automatic read_entry(input string name, input logic [3:0] addr);
    rf_pkg::rf_cmd_t c;
    rf_pkg::rf_rsp_t r;
    c      = '0;
    c.addr = addr;
    run_command(c, 0, r);
    compare_value({name, " read data"}, model_mem[addr].data, r.data);
    compare_value({name, " read check"}, model_mem[addr].check, r.check);
    if (model_inject[addr] == '0) begin
      compare_value({name, " read status"}, rf_pkg::STAT_CLEAN, r.status);
    end else if ($onehot(model_inject[addr])) begin
      compare_value({name, " read status"}, rf_pkg::STAT_CORR_CHECK, r.status);
    end else begin
      assert (r.status != rf_pkg::STAT_CLEAN) else begin
        check_errors++;
        $display("MISMATCH %s read status expected not %0d actual %0d", name,
                 rf_pkg::STAT_CLEAN, r.status);
      end
    end
  endtask

  initial begin : stimulus
    logic [63:0] a;
    logic [63:0] d;
    logic [63:0] sel;
    int unsigned assert_errors;
    rst_n = 1'b0;
    req   = 1'b0;
    cmd   = '0;
    for (int i = 0; i < rf_pkg::DEPTH; i++) begin
      model_valid[i] = 1'b0;
    end
    repeat (RESET_CYCLES) @(posedge clk);
    rst_n <= 1'b1;
    @(posedge clk);

    draw_bits(4, a);
    draw_bits(64, d);
    write_entry("write_clean", a[3:0], d, 8'h00, 0);
    read_entry("write_clean", a[3:0]);

    // Single check bit inverted on store
    draw_bits(4, a);
    draw_bits(64, d);
    draw_bits(3, sel);
    write_entry("inject_one", a[3:0], d, 8'h01 << sel[2:0], 0);
    read_entry("inject_one", a[3:0]);

    // Two check bits four positions apart
    draw_bits(4, a);
    draw_bits(64, d);
    draw_bits(3, sel);
    write_entry("inject_two", a[3:0], d,
                (8'h01 << sel[2:0]) | (8'h01 << (sel[2:0] + 3'd4)), 0);
    read_entry("inject_two", a[3:0]);

    repeat (20) begin
      draw_bits(4, a);
      draw_bits(64, d);
      write_entry("random", a[3:0], d, 8'h00, 0);
    end
    for (int i = 0; i < rf_pkg::DEPTH; i++) begin
      if (model_valid[i]) begin
        read_entry("sweep", 4'(i));
      end
    end

    draw_bits(4, a);
    draw_bits(64, d);
    write_entry("hold", a[3:0], d, 8'h00, 5);
    read_entry("hold", a[3:0]);

    repeat (2) @(posedge clk);
    assert_errors = u_ecc_rf_top.u_ecc_rf_ctrl.u_ecc_rf_asserts.fail_cnt;
    $display("Check errors: %0d, assertion errors: %0d", check_errors, assert_errors);
    if (check_errors == 0 && assert_errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

  initial begin : watchdog
    while (cycles < TIMEOUT_CYCLES) begin
      @(posedge clk);
      cycles++;
    end
    $display("Run timed out after %0d cycles before all commands completed", cycles);
    $display("Check errors: %0d, assertion errors: %0d", check_errors,
             u_ecc_rf_top.u_ecc_rf_ctrl.u_ecc_rf_asserts.fail_cnt);
    $display("Finished with errors");
    $finish;
  end

endmodule : ecc_rf_tb

`default_nettype wire

//--- ecc_rf.f
source/ecc_pkg.sv
source/rf_pkg.sv
source/ecc_gen.sv
source/ecc_check.sv
source/ecc_rf_array.sv
source/ecc_rf_ctrl.sv
source/ecc_rf_top.sv
tb/ecc_rf_asserts.sv
tb/ecc_rf_tb.sv

//--- Bender.yml
package:
  name: ecc_rf

sources:
  - files:
      - source/ecc_pkg.sv
      - source/rf_pkg.sv
      - source/ecc_gen.sv
      - source/ecc_check.sv
      - source/ecc_rf_array.sv
      - source/ecc_rf_ctrl.sv
      - source/ecc_rf_top.sv
  - target: test
    files:
      - tb/ecc_rf_asserts.sv
      - tb/ecc_rf_tb.sv
